// ==== common/xgmii_rx_pkg.sv ====
// lane 0 start only; the CRC register is reflected and never inverted, so a good frame leaves the residue
`default_nettype none

package xgmii_rx_pkg;

    // ----------------------------------------------------------
    // bus widths
    // ----------------------------------------------------------
    localparam int XGMII_DATA_W = 64;
    localparam int XGMII_CTRL_W = 8;
    localparam int LANES        = 8;
    localparam int BYTE_CNT_W   = 4;
    localparam int FCS_BYTES    = 4;
    localparam int STAT_W       = 32;

    // ----------------------------------------------------------
    // xgmii control characters
    // ----------------------------------------------------------
    localparam logic [7:0] CHAR_START = 8'hFB;
    localparam logic [7:0] CHAR_TERM  = 8'hFD;
    localparam logic [7:0] CHAR_IDLE  = 8'h07;

    // ----------------------------------------------------------
    // crc-32, ieee 802.3
    // ----------------------------------------------------------
    localparam logic [31:0] CRC_PRESET    = 32'hFFFF_FFFF;
    localparam logic [31:0] CRC_POLY_REFL = 32'hEDB8_8320;
    localparam logic [31:0] CRC_RESIDUE   = 32'hDEBB_20E3;

    // one byte into the crc register, lsb first
    function automatic logic [31:0] crc32_byte(input logic [31:0] crc, input logic [7:0] b);
        logic [31:0] c;
        c = crc ^ {24'h0, b};
        for (int i = 0; i < 8; i++) begin
            if (c[0]) begin
                c = (c >> 1) ^ CRC_POLY_REFL;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

endpackage

`default_nettype wire

// ==== common/xgmii_word_if.sv ====
// one decoded word per vld pulse; eof words carry the terminate lane in nbytes, err words carry 0
`timescale 1ns/1ns
`default_nettype none

interface xgmii_word_if import xgmii_rx_pkg::*; ();

    logic                    vld;
    logic                    sof;
    logic                    eof;
    logic                    err;
    logic [XGMII_DATA_W-1:0] data;
    // valid bytes sit in lanes 0 to nbytes-1
    logic [BYTE_CNT_W-1:0]   nbytes;

    modport decoder (output vld, sof, eof, err, data, nbytes);

    // stripper and checker both listen
    modport consumer (input vld, sof, eof, err, data, nbytes);

endinterface

`default_nettype wire

// ==== common/axis_beat_if.sv ====
// no ready signal, a beat lasts exactly one cycle and cannot be stalled
`timescale 1ns/1ns
`default_nettype none

interface axis_beat_if import xgmii_rx_pkg::*; ();

    logic                    vld;
    logic [XGMII_DATA_W-1:0] data;
    logic [LANES-1:0]        keep;
    // the frame verdict belongs to this beat
    logic                    last;

    modport stripper (output vld, data, keep, last);

    modport receiver (input vld, data, keep, last);

endinterface

`default_nettype wire

// ==== hw/xgmii_rx/xgmii_word_decoder.sv ====
// only a lane 0 start word opens a frame; preamble bytes are not checked, two cycles of latency
`timescale 1ns/1ns
`default_nettype none

module xgmii_word_decoder import xgmii_rx_pkg::*; (
    input  logic                    clk,
    input  logic                    inv_aresetn,
    input  logic [XGMII_DATA_W-1:0] xgmii_d_i,
    input  logic [XGMII_CTRL_W-1:0] xgmii_c_i,
    xgmii_word_if.decoder           word_o
);

    typedef enum logic {
        ST_IDLE,
        ST_FRAME
    } state_t;

    state_t                  state_q;
    logic                    first_q;
    logic [XGMII_DATA_W-1:0] d_q;
    logic [XGMII_CTRL_W-1:0] c_q;
    logic                    is_start;
    logic                    is_data;
    logic                    is_term;
    logic [BYTE_CNT_W-1:0]   term_lane;

    // ----------------------------------------------------------
    // word classification
    // ----------------------------------------------------------
    assign is_start = (c_q == XGMII_CTRL_W'(1)) && (d_q[7:0] == CHAR_START);
    assign is_data  = (c_q == '0);

    // terminate: all lanes from t upward are control, lane t holds 0xfd
    always_comb begin
        is_term   = 1'b0;
        term_lane = '0;
        for (int i = 0; i < LANES; i++) begin
            if ((c_q == ({XGMII_CTRL_W{1'b1}} << i)) && (d_q[8*i +: 8] == CHAR_TERM)) begin
                is_term   = 1'b1;
                term_lane = BYTE_CNT_W'(i);
            end
        end
    end

    // ----------------------------------------------------------
    // input lanes and state
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        d_q <= xgmii_d_i;
        if (inv_aresetn) begin
            c_q          <= '1;
            state_q      <= ST_IDLE;
            first_q      <= 1'b0;
            word_o.vld   <= 1'b0;
            word_o.sof   <= 1'b0;
            word_o.eof   <= 1'b0;
            word_o.err   <= 1'b0;
        end else begin
            c_q        <= xgmii_c_i;
            word_o.vld <= 1'b0;
            word_o.sof <= 1'b0;
            word_o.eof <= 1'b0;
            word_o.err <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (is_start) begin
                        state_q <= ST_FRAME;
                        first_q <= 1'b1;
                    end
                end
                ST_FRAME: begin
                    word_o.vld <= 1'b1;
                    word_o.sof <= first_q;
                    first_q    <= 1'b0;
                    if (!is_data) begin
                        // any control use ends the frame
                        word_o.eof <= 1'b1;
                        word_o.err <= !is_term;
                        state_q    <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // payload side
    always_ff @(posedge clk) begin
        word_o.data <= d_q;
        if (is_data) begin
            word_o.nbytes <= BYTE_CNT_W'(LANES);
        end else if (is_term) begin
            word_o.nbytes <= term_lane;
        end else begin
            word_o.nbytes <= '0;
        end
    end

endmodule

`default_nettype wire

// ==== hw/xgmii_rx/fcs_stripper.sv ====
// expects at least one full data word before the fcs; an aborted frame ends on the held word
`timescale 1ns/1ns
`default_nettype none

module fcs_stripper import xgmii_rx_pkg::*; (
    input  logic           clk,
    input  logic           inv_aresetn,
    xgmii_word_if.consumer word_i,
    axis_beat_if.stripper  beat_o
);

    logic [XGMII_DATA_W-1:0] hold_data_q;
    logic                    hold_vld_q;
    logic [XGMII_DATA_W-1:0] pend_data_q;
    logic [LANES-1:0]        pend_keep_q;
    logic                    pend_vld_q;
    logic                    short_end;

    // keep with the n lowest lanes set, n from 0 to 8
    function automatic logic [LANES-1:0] low_lanes(input logic [BYTE_CNT_W-1:0] n);
        return {LANES{1'b1}} >> (BYTE_CNT_W'(LANES) - n);
    endfunction

    // fcs fits in the held word plus the eof word
    assign short_end = (word_i.nbytes <= BYTE_CNT_W'(FCS_BYTES));

    // ----------------------------------------------------------
    // beat control
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (inv_aresetn) begin
            hold_vld_q  <= 1'b0;
            pend_vld_q  <= 1'b0;
            beat_o.vld  <= 1'b0;
            beat_o.last <= 1'b0;
        end else begin
            beat_o.vld  <= 1'b0;
            beat_o.last <= 1'b0;
            pend_vld_q  <= 1'b0;
            if (pend_vld_q) begin
                // trailing bytes of a t > 4 frame
                beat_o.vld  <= 1'b1;
                beat_o.last <= 1'b1;
            end else if (word_i.vld) begin
                if (word_i.err) begin
                    beat_o.vld  <= 1'b1;
                    beat_o.last <= 1'b1;
                    hold_vld_q  <= 1'b0;
                end else if (word_i.eof) begin
                    beat_o.vld  <= 1'b1;
                    beat_o.last <= short_end;
                    pend_vld_q  <= !short_end;
                    hold_vld_q  <= 1'b0;
                end else begin
                    beat_o.vld <= hold_vld_q;
                    hold_vld_q <= 1'b1;
                end
            end
        end
    end

    // ----------------------------------------------------------
    // beat payload
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (pend_vld_q) begin
            beat_o.data <= pend_data_q;
            beat_o.keep <= pend_keep_q;
        end else if (word_i.vld) begin
            beat_o.data <= hold_data_q;
            if (word_i.err) begin
                beat_o.keep <= hold_vld_q ? {LANES{1'b1}} : '0;
            end else if (word_i.eof && short_end) begin
                beat_o.keep <= low_lanes(BYTE_CNT_W'(FCS_BYTES) + word_i.nbytes);
            end else begin
                beat_o.keep <= {LANES{1'b1}};
            end
            if (!word_i.eof) begin
                hold_data_q <= word_i.data;
            end
            pend_data_q <= word_i.data;
            pend_keep_q <= low_lanes(word_i.nbytes - BYTE_CNT_W'(FCS_BYTES));
        end
    end

endmodule

`default_nettype wire

// ==== hw/xgmii_rx/fcs_checker.sv ====
// crc covers every frame byte including the fcs; the verdict pulses one cycle after the eof word
`timescale 1ns/1ns
`default_nettype none

module fcs_checker import xgmii_rx_pkg::*; (
    input  logic           clk,
    input  logic           inv_aresetn,
    xgmii_word_if.consumer word_i,
    output logic           fcs_done_o,
    output logic           fcs_ok_o
);

    logic [31:0] crc_q;
    logic [31:0] crc_next;

    // ----------------------------------------------------------
    // fold the valid lanes of one word
    // ----------------------------------------------------------
    always_comb begin
        crc_next = word_i.sof ? CRC_PRESET : crc_q;
        for (int i = 0; i < LANES; i++) begin
            if (BYTE_CNT_W'(i) < word_i.nbytes) begin
                crc_next = crc32_byte(crc_next, word_i.data[8*i +: 8]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (word_i.vld) begin
            crc_q <= crc_next;
        end
    end

    // ----------------------------------------------------------
    // verdict
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (inv_aresetn) begin
            fcs_done_o <= 1'b0;
            fcs_ok_o   <= 1'b0;
        end else begin
            fcs_done_o <= word_i.vld && word_i.eof;
            if (word_i.vld && word_i.eof) begin
                // an aborted frame never passes
                fcs_ok_o <= !word_i.err && (crc_next == CRC_RESIDUE);
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/xgmii_rx/frame_status_merger.sv ====
// the verdict must arrive with the last beat or one cycle before it; counters wrap silently
`timescale 1ns/1ns
`default_nettype none

module frame_status_merger import xgmii_rx_pkg::*; (
    input  logic                    clk,
    input  logic                    inv_aresetn,
    axis_beat_if.receiver           beat_i,
    input  logic                    fcs_done_i,
    input  logic                    fcs_ok_i,
    output logic [XGMII_DATA_W-1:0] tdata_o,
    output logic [LANES-1:0]        tkeep_o,
    output logic                    tvalid_o,
    output logic                    tlast_o,
    output logic                    tuser_o,
    output logic [STAT_W-1:0]       good_frames_o,
    output logic [STAT_W-1:0]       bad_frames_o
);

    logic verdict_q;
    logic verdict;

    // same-cycle verdict bypasses the latch
    assign verdict = fcs_done_i ? fcs_ok_i : verdict_q;

    // ----------------------------------------------------------
    // output stage and counters
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (inv_aresetn) begin
            verdict_q     <= 1'b0;
            tvalid_o      <= 1'b0;
            tlast_o       <= 1'b0;
            tuser_o       <= 1'b0;
            good_frames_o <= '0;
            bad_frames_o  <= '0;
        end else begin
            if (fcs_done_i) begin
                verdict_q <= fcs_ok_i;
            end
            tvalid_o <= beat_i.vld;
            tlast_o  <= beat_i.vld && beat_i.last;
            tuser_o  <= beat_i.vld && beat_i.last && verdict;
            if (tvalid_o && tlast_o) begin
                if (tuser_o) begin
                    good_frames_o <= good_frames_o + STAT_W'(1);
                end else begin
                    bad_frames_o <= bad_frames_o + STAT_W'(1);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        tdata_o <= beat_i.data;
        tkeep_o <= beat_i.keep;
    end

endmodule

`default_nettype wire

// ==== hw/xgmii_axis_rx.sv ====
// lane 0 start only, no back-pressure; output latency depends on the terminate lane
`timescale 1ns/1ns
`default_nettype none

module xgmii_axis_rx import xgmii_rx_pkg::*; (
    input  logic                    clk,
    input  logic                    inv_aresetn,
    input  logic [XGMII_DATA_W-1:0] xgmii_d_i,
    input  logic [XGMII_CTRL_W-1:0] xgmii_c_i,
    output logic [XGMII_DATA_W-1:0] tdata_o,
    output logic [LANES-1:0]        tkeep_o,
    output logic                    tvalid_o,
    output logic                    tlast_o,
    output logic                    tuser_o,
    output logic [STAT_W-1:0]       good_frames_o,
    output logic [STAT_W-1:0]       bad_frames_o
);

    logic fcs_done;
    logic fcs_ok;

    xgmii_word_if word_if ();
    axis_beat_if  beat_if ();

    xgmii_word_decoder u_decoder (
        .clk         (clk),
        .inv_aresetn (inv_aresetn),
        .xgmii_d_i   (xgmii_d_i),
        .xgmii_c_i   (xgmii_c_i),
        .word_o      (word_if)
    );

    // ----------------------------------------------------------
    // stripper and checker run side by side on the same words
    // ----------------------------------------------------------
    fcs_stripper u_stripper (
        .clk         (clk),
        .inv_aresetn (inv_aresetn),
        .word_i      (word_if),
        .beat_o      (beat_if)
    );

    fcs_checker u_checker (
        .clk         (clk),
        .inv_aresetn (inv_aresetn),
        .word_i      (word_if),
        .fcs_done_o  (fcs_done),
        .fcs_ok_o    (fcs_ok)
    );

    frame_status_merger u_merger (
        .clk           (clk),
        .inv_aresetn   (inv_aresetn),
        .beat_i        (beat_if),
        .fcs_done_i    (fcs_done),
        .fcs_ok_i      (fcs_ok),
        .tdata_o       (tdata_o),
        .tkeep_o       (tkeep_o),
        .tvalid_o      (tvalid_o),
        .tlast_o       (tlast_o),
        .tuser_o       (tuser_o),
        .good_frames_o (good_frames_o),
        .bad_frames_o  (bad_frames_o)
    );

endmodule

`default_nettype wire

// ==== tests/tb_xgmii_axis_rx_tests.svh ====
// included inside the testbench module; each test leaves the line idle and the DUT drained
`ifndef TB_XGMII_AXIS_RX_TESTS_SVH
`define TB_XGMII_AXIS_RX_TESTS_SVH

// one frame expected with the given tuser on its only tlast
task automatic expect_single_frame(input logic user);
    wait_frames(1);
    settle(3);
    compare_rx();
    check_value("tlast count", 64'd1, 64'(rx_lens.size()));
    check_value("tuser", 64'(user), 64'(rx_users[0]));
endtask

// ------------------------------------------------------------
// good frames with the terminate in every lane
// ------------------------------------------------------------
task automatic good_frame_sweep();
    logic [31:0] good_before;
    int          len;
    for (len = 8; len <= 23; len++) begin
        test_name   = $sformatf("good_frame_sweep len %0d", len);
        good_before = good_frames;
        fill_payload(len);
        exp_bytes = tx_payload;
        clear_monitor();
        send_frame(1'b0, -1);
        expect_single_frame(1'b1);
        check_value("good count", 64'(good_before + 32'd1), 64'(good_frames));
    end
endtask

task automatic corrupted_fcs();
    logic [31:0] good_before;
    logic [31:0] bad_before;
    test_name   = "corrupted_fcs";
    good_before = good_frames;
    bad_before  = bad_frames;
    fill_payload(30);
    exp_bytes = tx_payload;
    clear_monitor();
    send_frame(1'b1, -1);
    expect_single_frame(1'b0);
    check_value("bad count", 64'(bad_before + 32'd1), 64'(bad_frames));
    check_value("good count", 64'(good_before), 64'(good_frames));
endtask

// ------------------------------------------------------------
// abort in the second data word and then a clean frame
// ------------------------------------------------------------
task automatic control_error();
    logic [31:0] good_before;
    logic [31:0] bad_before;
    int          k;
    test_name   = "control_error";
    good_before = good_frames;
    bad_before  = bad_frames;
    fill_payload(20);
    // only the first data word survives
    exp_bytes.delete();
    for (k = 0; k < 8; k++) begin
        exp_bytes.push_back(tx_payload[k]);
    end
    clear_monitor();
    send_frame(1'b0, 1);
    expect_single_frame(1'b0);
    check_value("bad count", 64'(bad_before + 32'd1), 64'(bad_frames));
    test_name = "control_error recovery";
    fill_payload(17);
    exp_bytes = tx_payload;
    clear_monitor();
    send_frame(1'b0, -1);
    expect_single_frame(1'b1);
    check_value("good count", 64'(good_before + 32'd1), 64'(good_frames));
endtask

task automatic back_to_back();
    logic [31:0] r;
    int          lens[$];
    int          len;
    int          n;
    test_name = "back_to_back";
    apply_reset();
    clear_monitor();
    exp_bytes.delete();
    for (n = 0; n < 8; n++) begin
        r   = lcg_next();
        len = 8 + int'(r[30:16]) % 33;
        lens.push_back(len);
        fill_payload(len);
        foreach (tx_payload[k]) begin
            exp_bytes.push_back(tx_payload[k]);
        end
        send_frame(1'b0, -1);
    end
    wait_frames(8);
    settle(3);
    compare_rx();
    check_value("tlast count", 64'd8, 64'(rx_lens.size()));
    foreach (lens[k]) begin
        check_value($sformatf("frame %0d length", k), 64'(lens[k]), 64'(rx_lens[k]));
        check_value($sformatf("frame %0d tuser", k), 64'd1, 64'(rx_users[k]));
    end
    check_value("good count", 64'd8, 64'(good_frames));
    check_value("bad count", 64'd0, 64'(bad_frames));
endtask

// ------------------------------------------------------------
// reset clears the counters and the output stays quiet
// ------------------------------------------------------------
task automatic reset_behavior();
    logic [31:0] good_before;
    logic [31:0] bad_before;
    int          beats_before;
    test_name   = "reset_behavior";
    good_before = good_frames;
    bad_before  = bad_frames;
    // one bad and one good frame so both counters are nonzero
    fill_payload(12);
    exp_bytes = tx_payload;
    clear_monitor();
    send_frame(1'b1, -1);
    expect_single_frame(1'b0);
    check_value("bad count before reset", 64'(bad_before + 32'd1), 64'(bad_frames));
    fill_payload(12);
    exp_bytes = tx_payload;
    clear_monitor();
    send_frame(1'b0, -1);
    expect_single_frame(1'b1);
    check_value("good count before reset", 64'(good_before + 32'd1), 64'(good_frames));
    beats_before = beat_count;
    apply_reset();
    settle(1);
    check_value("good count after reset", 64'd0, 64'(good_frames));
    check_value("bad count after reset", 64'd0, 64'(bad_frames));
    settle(20);
    check_value("beats while idle", 64'(beats_before), 64'(beat_count));
    check_value("tvalid", 64'd0, 64'(tvalid));
    check_value("good count after idles", 64'd0, 64'(good_frames));
    check_value("bad count after idles", 64'd0, 64'(bad_frames));
endtask

`endif

// ==== tests/tb_xgmii_axis_rx.sv ====
// directed tests only; frames start in lane 0, carry at least 8 payload bytes, stop at first error
`timescale 1ns/1ns
`default_nettype none

module tb_xgmii_axis_rx;

    localparam int CLK_PERIOD   = 100;
    localparam int DRIVE_DELAY  = 5;
    localparam int RESET_CYCLES = 8;
    localparam int FRAME_WAIT   = 40;
    // watchdog budget is twice the longest frames plus drain and resets
    localparam int TOTAL_FRAMES    = 29;
    localparam int MAX_FRAME_WORDS = 8;
    localparam int DRAIN_CYCLES    = 12;
    localparam int WATCHDOG_CYCLES = 2 * (TOTAL_FRAMES * (MAX_FRAME_WORDS + DRAIN_CYCLES)
                                          + 3 * (RESET_CYCLES + 1) + 40);
    localparam logic [63:0] IDLE_WORD = {8{8'h07}};

    logic        clk;
    logic        inv_aresetn;
    logic [63:0] xgmii_d;
    logic [7:0]  xgmii_c;
    logic [63:0] tdata;
    logic [7:0]  tkeep;
    logic        tvalid;
    logic        tlast;
    logic        tuser;
    logic [31:0] good_frames;
    logic [31:0] bad_frames;

    logic [31:0] lcg_state;
    string       test_name;
    logic [7:0]  tx_payload[$];
    logic [7:0]  exp_bytes[$];
    logic [7:0]  rx_bytes[$];
    int          rx_lens[$];
    logic        rx_users[$];
    int          cur_len;
    int          beat_count;

    xgmii_axis_rx UUT (
        .clk           (clk),
        .inv_aresetn   (inv_aresetn),
        .xgmii_d_i     (xgmii_d),
        .xgmii_c_i     (xgmii_c),
        .tdata_o       (tdata),
        .tkeep_o       (tkeep),
        .tvalid_o      (tvalid),
        .tlast_o       (tlast),
        .tuser_o       (tuser),
        .good_frames_o (good_frames),
        .bad_frames_o  (bad_frames)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Result: FAILED");
        $fatal(1, "watchdog expired");
    end

    // ----------------------------------------------------------
    // output monitor sampling mid-cycle
    // ----------------------------------------------------------
    always @(negedge clk) begin : monitor
        int i;
        if (tvalid) begin
            beat_count++;
            for (i = 0; i < 8; i++) begin
                if (tkeep[i]) begin
                    rx_bytes.push_back(tdata[8*i +: 8]);
                    cur_len++;
                end
            end
            if (tlast) begin
                rx_lens.push_back(cur_len);
                rx_users.push_back(tuser);
                cur_len = 0;
            end
        end
    end

    // ----------------------------------------------------------
    // helpers
    // ----------------------------------------------------------
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // reflected crc-32 worked one bit at a time
    function automatic logic [31:0] crc_update(input logic [31:0] crc, input logic [7:0] b);
        logic [31:0] r;
        logic        fb;
        int          i;
        r = crc;
        for (i = 0; i < 8; i++) begin
            fb = r[0] ^ b[i];
            r  = r >> 1;
            if (fb) begin
                r = r ^ 32'hEDB8_8320;
            end
        end
        return r;
    endfunction

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("ERR %s %s: expected 0x%0h, actual 0x%0h", test_name, what, expected, actual);
            $display("Result: FAILED");
            $fatal(1, "check failed");
        end
    endtask

    task automatic drive_word(input logic [63:0] d, input logic [7:0] c);
        @(posedge clk);
        #DRIVE_DELAY;
        xgmii_d = d;
        xgmii_c = c;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #DRIVE_DELAY;
        inv_aresetn = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        inv_aresetn = 1'b0;
    endtask

    task automatic settle(input int cycles);
        repeat (cycles) @(negedge clk);
    endtask

    task automatic clear_monitor();
        rx_bytes.delete();
        rx_lens.delete();
        rx_users.delete();
        cur_len = 0;
    endtask

    task automatic fill_payload(input int len);
        logic [31:0] r;
        int          k;
        tx_payload.delete();
        for (k = 0; k < len; k++) begin
            r = lcg_next();
            tx_payload.push_back(r[23:16]);
        end
    endtask

    task automatic wait_frames(input int count);
        int cycles;
        cycles = 0;
        while (rx_lens.size() < count) begin
            @(negedge clk);
            cycles++;
            if (cycles > FRAME_WAIT * count) begin
                $display("timeout: %s saw %0d of %0d frame ends", test_name, rx_lens.size(), count);
                $display("Result: FAILED");
                $fatal(1, "frame end missing");
            end
        end
    endtask

    task automatic compare_rx();
        check_value("byte count", 64'(exp_bytes.size()), 64'(rx_bytes.size()));
        foreach (exp_bytes[k]) begin
            check_value($sformatf("byte %0d", k), 64'(exp_bytes[k]), 64'(rx_bytes[k]));
        end
    endtask

    // start word, payload and fcs, terminate word, then one idle
    task automatic send_frame(input logic corrupt_fcs, input int err_word);
        logic [7:0]  fb[$];
        logic [31:0] crc;
        logic [63:0] d;
        int          nfull;
        int          rem;
        int          w;
        int          i;
        crc = 32'hFFFF_FFFF;
        fb  = tx_payload;
        foreach (tx_payload[k]) begin
            crc = crc_update(crc, tx_payload[k]);
        end
        // fcs goes out inverted with the low byte first
        crc = ~crc;
        if (corrupt_fcs) begin
            crc[13] = ~crc[13];
        end
        for (i = 0; i < 4; i++) begin
            fb.push_back(crc[8*i +: 8]);
        end
        drive_word({8'hD5, {6{8'h55}}, 8'hFB}, 8'h01);
        nfull = fb.size() / 8;
        rem   = fb.size() % 8;
        for (w = 0; w < nfull; w++) begin
            for (i = 0; i < 8; i++) begin
                d[8*i +: 8] = fb[8*w + i];
            end
            if (w == err_word) begin
                // stray error character in lane 3
                d[31:24] = 8'hFE;
                drive_word(d, 8'h08);
            end else begin
                drive_word(d, 8'h00);
            end
        end
        d = IDLE_WORD;
        for (i = 0; i < rem; i++) begin
            d[8*i +: 8] = fb[8*nfull + i];
        end
        d[8*rem +: 8] = 8'hFD;
        drive_word(d, 8'hFF << rem);
        drive_word(IDLE_WORD, 8'hFF);
    endtask

    `include "tb_xgmii_axis_rx_tests.svh"

    // ----------------------------------------------------------
    // test sequence
    // ----------------------------------------------------------
    initial begin
        inv_aresetn = 1'b1;
        xgmii_d     = IDLE_WORD;
        xgmii_c     = 8'hFF;
        lcg_state   = 32'd99;
        beat_count  = 0;
        test_name   = "startup";
        clear_monitor();
        apply_reset();
        good_frame_sweep();
        corrupted_fcs();
        control_error();
        back_to_back();
        reset_behavior();
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== xgmii_axis_rx.f ====
+incdir+tests
common/xgmii_rx_pkg.sv
common/xgmii_word_if.sv
common/axis_beat_if.sv
hw/xgmii_rx/xgmii_word_decoder.sv
hw/xgmii_rx/fcs_stripper.sv
hw/xgmii_rx/fcs_checker.sv
hw/xgmii_rx/frame_status_merger.sv
hw/xgmii_axis_rx.sv
tests/tb_xgmii_axis_rx.sv

// ==== Makefile ====
SIM       ?= verilator
TOP       ?= tb_xgmii_axis_rx
FILELIST  ?= xgmii_axis_rx.f
BUILD_DIR ?= obj_dir
SIMFLAGS  ?= --binary --timing --timescale 1ns/1ns
PASS_MSG  ?= Result: PASSED

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) tests/tb_xgmii_axis_rx_tests.svh
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIMFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
